// ==== verilog.f ====
+incdir+include
hw/exec_pkg.sv
hw/exec_intf.sv
hw/alu.sv
hw/mul_div_shift.sv
hw/data_mem_port.sv
hw/exec_ctrl.sv
hw/exec_core.sv
test/tb_exec_core.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the execute stage testbench with Verilator and runs it.
# The result is taken from the pass message in the simulation log.

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing -Wno-fatal -f verilog.f --top-module tb_exec_core
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/Vtb_exec_core > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "^Testbench passed$" "$log"; then
	exit 0
fi
echo "Pass message not found in $log"
exit 1

// ==== include/exec_ref.svh ====
/*
 * Reference model functions for the execute stage testbench.
 * Included inside the testbench module to predict results and next PC.
 */
`ifndef EXEC_REF_SVH
`define EXEC_REF_SVH

function automatic exec_pkg::word_t ref_alu(exec_pkg::word_t a, exec_pkg::word_t b,
		exec_pkg::alu_op_e op);
	case (op)
		exec_pkg::alu_add: return a + b;
		exec_pkg::alu_sub: return a - b;
		exec_pkg::alu_and: return a & b;
		exec_pkg::alu_or: return a | b;
		exec_pkg::alu_xor: return a ^ b;
		exec_pkg::alu_slt, exec_pkg::alu_lt: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
		exec_pkg::alu_sltu, exec_pkg::alu_ltu: return (a < b) ? 32'd1 : 32'd0;
		exec_pkg::alu_eq: return (a == b) ? 32'd1 : 32'd0;
		exec_pkg::alu_ne: return (a != b) ? 32'd1 : 32'd0;
		exec_pkg::alu_ge: return ($signed(a) >= $signed(b)) ? 32'd1 : 32'd0;
		exec_pkg::alu_geu: return (a >= b) ? 32'd1 : 32'd0;
		exec_pkg::alu_pass_b: return b;
		default: return '0;
	endcase
endfunction

function automatic exec_pkg::word_t ref_mds(exec_pkg::word_t a, exec_pkg::word_t b,
		exec_pkg::mds_op_e op);
	logic signed [63:0] sprod;
	logic overflow;
	sprod = $signed(a) * $signed(b);
	// Signed divide of the most negative value by -1
	overflow = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
	case (op)
		exec_pkg::mds_sll: return a << b[4:0];
		exec_pkg::mds_srl: return a >> b[4:0];
		exec_pkg::mds_sra: return $signed(a) >>> b[4:0];
		exec_pkg::mds_mul: return sprod[31:0];
		exec_pkg::mds_mulh: return sprod[63:32];
		exec_pkg::mds_div: begin
			if (b == '0) return '1;
			if (overflow) return a;
			return $signed(a) / $signed(b);
		end
		exec_pkg::mds_divu: begin
			if (b == '0) return '1;
			return a / b;
		end
		exec_pkg::mds_rem: begin
			if (b == '0) return a;
			if (overflow) return '0;
			return $signed(a) % $signed(b);
		end
		exec_pkg::mds_remu: begin
			if (b == '0) return a;
			return a % b;
		end
		default: return '0;
	endcase
endfunction

function automatic exec_pkg::word_t ref_load(exec_pkg::word_t rdata, logic [1:0] addr_lo,
		exec_pkg::mem_op_e op);
	exec_pkg::word_t lane;
	lane = rdata >> {addr_lo, 3'b000};
	case (op)
		exec_pkg::mem_lb: return {{24{lane[7]}}, lane[7:0]};
		exec_pkg::mem_lbu: return {24'd0, lane[7:0]};
		exec_pkg::mem_lh: return {{16{lane[15]}}, lane[15:0]};
		exec_pkg::mem_lhu: return {16'd0, lane[15:0]};
		default: return lane;
	endcase
endfunction

function automatic exec_pkg::word_t ref_next_pc(exec_pkg::word_t pc, logic instr_c);
	return pc + (instr_c ? 32'd2 : 32'd4);
endfunction

`endif

// ==== test/tb_exec_core.sv ====
/*
 * Testbench for the execute stage. Issues random instructions of every class,
 * models the data memory on the bus and checks write-back, next PC, store
 * strobes and completion against the reference functions in exec_ref.svh.
 */
`timescale 1ns/1ps

module tb_exec_core;

	`include "exec_ref.svh"

	localparam int n_arith = 70;
	localparam int n_branch = 60;
	localparam int n_jump = 40;
	localparam int n_store = 50;
	localparam int n_load = 60;
	localparam int n_mds = 100;
	// Upper bounds for the watchdog
	localparam int max_instr = 400;
	localparam int max_cycles = 40;
	localparam int clock_period = 20;

	logic clock;
	logic reset;
	logic decode_valid;
	logic instr_c;
	exec_pkg::op_type_e op_type;
	exec_pkg::op_t op;
	exec_pkg::word_t op_a;
	exec_pkg::word_t op_b;
	exec_pkg::word_t op_c;
	exec_pkg::reg_addr_t rd;
	logic instr_complete;
	exec_pkg::reg_addr_t rd_waddr;
	exec_pkg::word_t rd_wdata;
	logic rd_wen;
	exec_pkg::word_t pc;
	logic pc_seq;
	exec_pkg::word_t daddr;
	logic dvalid;
	logic dwrite;
	exec_pkg::word_t dwdata;
	exec_pkg::byte_en_t dwstb;
	exec_pkg::word_t drdata = '0;
	logic dready = 1'b0;

	// Memory behind the bus, and the checker's own copy of it
	exec_pkg::word_t bus_mem [256];
	exec_pkg::word_t shadow [256];
	int wait_cnt;
	exec_pkg::word_t model_pc;
	int cycles;
	int wen_seen;
	int issued;
	int completed;
	int checks;
	int errors;

	exec_core #(.ENABLE_MUL_DIV(1'b1)) exec_core_i (.*);

	always #(clock_period / 2) clock = ~clock;

	task automatic report_error(string msg);
		errors++;
		$display("ERROR %0t: %s", $time, msg);
	endtask

	function automatic exec_pkg::word_t fill_word(int idx);
		logic [7:0] a;
		a = 8'(idx);
		return {a, ~a, a ^ 8'h5a, a + 8'h33};
	endfunction

	// Mix of corner values and plain random words
	function automatic exec_pkg::word_t random_operand();
		case ($urandom % 8)
			0: return 32'd0;
			1: return 32'h8000_0000;
			2: return 32'hffff_ffff;
			3: return 32'd1 + ($urandom % 16);
			4: return 32'd0 - ($urandom % 16);
			default: return $urandom;
		endcase
	endfunction

	function automatic exec_pkg::word_t lane_mask(exec_pkg::byte_en_t stb);
		exec_pkg::word_t m;
		for (int i = 0; i < 4; i++) begin
			m[8*i +: 8] = {8{stb[i]}};
		end
		return m;
	endfunction

	// One strobe bit per byte the access covers, from the low address bits up
	function automatic exec_pkg::byte_en_t expected_strobe(exec_pkg::op_t o, logic [1:0] lo);
		exec_pkg::byte_en_t stb;
		int size;
		case (exec_pkg::mem_op_e'(o))
			exec_pkg::mem_sb: size = 1;
			exec_pkg::mem_sh: size = 2;
			exec_pkg::mem_sw: size = 4;
			default: size = 0;
		endcase
		for (int i = 0; i < 4; i++) begin
			stb[i] = (i >= lo) && (i < lo + size);
		end
		return stb;
	endfunction

	function automatic exec_pkg::word_t store_lanes(exec_pkg::op_t o, logic [1:0] lo,
			exec_pkg::word_t data);
		case (exec_pkg::mem_op_e'(o))
			exec_pkg::mem_sb: return {24'd0, data[7:0]} << {lo, 3'b000};
			exec_pkg::mem_sh: return {16'd0, data[15:0]} << {lo, 3'b000};
			default: return data;
		endcase
	endfunction

	function automatic logic writes_rd();
		case (op_type)
			exec_pkg::op_type_branch: return 1'b0;
			exec_pkg::op_type_ldst: return op <= 4'd4;
			default: return 1'b1;
		endcase
	endfunction

	// Jumps and taken branches leave the sequential path
	function automatic logic is_redirect();
		exec_pkg::word_t cmp;
		cmp = ref_alu(op_a, op_b, exec_pkg::alu_op_e'(op));
		return op_type == exec_pkg::op_type_jump
			|| (op_type == exec_pkg::op_type_branch && cmp[0]);
	endfunction

	function automatic int expected_latency();
		case (op_type)
			exec_pkg::op_type_arith: return 1;
			exec_pkg::op_type_branch, exec_pkg::op_type_jump: return is_redirect() ? 2 : 1;
			default: return 0;
		endcase
	endfunction

	function automatic exec_pkg::word_t expected_wdata(exec_pkg::word_t cur_pc);
		exec_pkg::word_t addr;
		addr = op_a + op_c;
		case (op_type)
			exec_pkg::op_type_arith: return ref_alu(op_a, op_b, exec_pkg::alu_op_e'(op));
			exec_pkg::op_type_jump: return ref_next_pc(cur_pc, instr_c);
			exec_pkg::op_type_mds: return ref_mds(op_a, op_b, exec_pkg::mds_op_e'(op));
			default: return ref_load(shadow[addr[9:2]], addr[1:0], exec_pkg::mem_op_e'(op));
		endcase
	endfunction

	function automatic exec_pkg::word_t expected_pc(exec_pkg::word_t cur_pc);
		if (op_type == exec_pkg::op_type_jump) begin
			return op_a + op_c;
		end
		if (is_redirect()) begin
			return cur_pc + op_c;
		end
		return ref_next_pc(cur_pc, instr_c);
	endfunction

	task automatic issue(exec_pkg::op_type_e t, exec_pkg::op_t o, exec_pkg::word_t a,
			exec_pkg::word_t b, exec_pkg::word_t c);
		@(posedge clock);
		decode_valid <= 1'b1;
		op_type <= t;
		op <= o;
		op_a <= a;
		op_b <= b;
		op_c <= c;
		rd <= exec_pkg::reg_addr_t'($urandom);
		instr_c <= 1'($urandom % 2);
		issued++;
		// Hold the instruction until the DUT completes it
		do begin
			@(negedge clock);
		end while (!instr_complete);
		@(posedge clock);
		decode_valid <= 1'b0;
	endtask

	task automatic run_branches(int n);
		exec_pkg::word_t a;
		exec_pkg::word_t b;
		repeat (n) begin
			a = random_operand();
			b = ($urandom % 2) ? a : random_operand();
			issue(exec_pkg::op_type_branch, exec_pkg::op_t'(7 + $urandom % 6), a, b,
				($urandom & 32'h0000_0ffe) - 32'h800);
		end
	endtask

	task automatic run_mem(int n, logic store);
		exec_pkg::op_t o;
		exec_pkg::word_t addr;
		exec_pkg::word_t a;
		repeat (n) begin
			o = store ? exec_pkg::op_t'(5 + $urandom % 3) : exec_pkg::op_t'($urandom % 5);
			// Small window so loads hit earlier stores
			addr = 32'h0002_0000 | ($urandom & 32'h7f);
			if (o == exec_pkg::mem_lw || o == exec_pkg::mem_sw) begin
				addr[1:0] = 2'b00;
			end else if (o == exec_pkg::mem_lh || o == exec_pkg::mem_lhu
					|| o == exec_pkg::mem_sh) begin
				addr[0] = 1'b0;
			end
			a = $urandom;
			issue(exec_pkg::op_type_ldst, o, a, $urandom, addr - a);
		end
	endtask

	task automatic check_reset_state();
		checks++;
		if (pc != exec_pkg::reset_pc || !pc_seq) begin
			report_error($sformatf("after reset pc %h seq %b, expected %h seq 1",
				pc, pc_seq, exec_pkg::reset_pc));
		end
		if (dvalid || rd_wen || instr_complete) begin
			report_error("dvalid, rd_wen or instr_complete high after reset");
		end
	endtask

	// Data memory answering after 0 to 3 wait cycles
	always @(posedge clock) begin
		if (reset) begin
			dready <= 1'b0;
			wait_cnt <= 0;
		end else if (dready) begin
			dready <= 1'b0;
		end else if (!dvalid) begin
			wait_cnt <= $urandom % 4;
		end else if (wait_cnt != 0) begin
			wait_cnt <= wait_cnt - 1;
		end else begin
			dready <= 1'b1;
			drdata <= bus_mem[daddr[9:2]];
			if (dwrite) begin
				for (int i = 0; i < 4; i++) begin
					if (dwstb[i]) begin
						bus_mem[daddr[9:2]][8*i +: 8] = dwdata[8*i +: 8];
					end
				end
			end
		end
	end

	// Checker sampling the DUT mid-cycle
	always @(negedge clock) begin
		exec_pkg::word_t want;
		exec_pkg::word_t mask;
		exec_pkg::word_t addr;
		logic store_op;
		if (reset) begin
			model_pc = exec_pkg::reset_pc;
			cycles = 0;
			wen_seen = 0;
			completed = 0;
		end else begin
			addr = op_a + op_c;
			store_op = exec_pkg::mem_op_e'(op) inside {exec_pkg::mem_sb, exec_pkg::mem_sh,
				exec_pkg::mem_sw};
			if (rd_wen) begin
				wen_seen++;
				checks++;
				want = expected_wdata(model_pc);
				if (!decode_valid) begin
					report_error("rd_wen raised with no instruction in flight");
				end else if (rd_waddr != rd || rd_wdata != want) begin
					report_error($sformatf("x%0d <= %h, expected x%0d <= %h (type %0d op %0d)",
						rd_waddr, rd_wdata, rd, want, op_type, op));
				end
			end
			if (dvalid && dready) begin
				checks++;
				if (dwrite != store_op) begin
					report_error($sformatf("dwrite %b on bus handshake, expected %b",
						dwrite, store_op));
				end
			end
			if (dvalid && dready && dwrite) begin
				checks++;
				mask = lane_mask(expected_strobe(op, addr[1:0]));
				want = store_lanes(op, addr[1:0], op_b);
				if (daddr != addr || dwstb != expected_strobe(op, addr[1:0])
						|| (dwdata & mask) != want) begin
					report_error($sformatf("store addr %h stb %b data %h, expected %h %b %h",
						daddr, dwstb, dwdata, addr, expected_strobe(op, addr[1:0]), want));
				end
				shadow[addr[9:2]] = (shadow[addr[9:2]] & ~mask) | want;
			end
			if (instr_complete) begin
				checks++;
				completed++;
				want = expected_pc(model_pc);
				if (completed != issued) begin
					report_error($sformatf("completion %0d with %0d issued", completed, issued));
				end
				if (pc != want || pc_seq != !is_redirect()) begin
					report_error($sformatf("pc %h seq %b, expected %h seq %b",
						pc, pc_seq, want, !is_redirect()));
				end
				if (wen_seen != (writes_rd() ? 1 : 0)) begin
					report_error($sformatf("rd_wen seen %0d times, expected %0d",
						wen_seen, writes_rd() ? 1 : 0));
				end
				if (expected_latency() != 0 && cycles != expected_latency()) begin
					report_error($sformatf("latency %0d cycles, expected %0d",
						cycles, expected_latency()));
				end
				model_pc = want;
				cycles = 0;
				wen_seen = 0;
			end else if (decode_valid) begin
				cycles++;
			end
		end
	end

	initial begin
		void'($urandom(32'h5e3e6237));
		errors = 0;
		checks = 0;
		issued = 0;
		clock = 1'b0;
		reset = 1'b1;
		decode_valid = 1'b0;
		instr_c = 1'b0;
		op_type = exec_pkg::op_type_arith;
		op = '0;
		op_a = '0;
		op_b = '0;
		op_c = '0;
		rd = '0;
		for (int i = 0; i < 256; i++) begin
			bus_mem[i] = fill_word(i);
			shadow[i] = fill_word(i);
		end
		repeat (16) @(posedge clock);
		reset <= 1'b0;
		@(negedge clock);
		check_reset_state();

		repeat (n_arith) begin
			issue(exec_pkg::op_type_arith, exec_pkg::op_t'($urandom % 14),
				random_operand(), random_operand(), 32'd0);
		end
		run_branches(n_branch);
		repeat (n_jump) begin
			issue(exec_pkg::op_type_jump, 4'd0, $urandom, 32'd0, $urandom & 32'h000f_fffe);
		end
		run_mem(n_store, 1'b1);
		run_mem(n_load, 1'b0);
		repeat (n_mds) begin
			issue(exec_pkg::op_type_mds, exec_pkg::op_t'($urandom % 9),
				random_operand(), random_operand(), 32'd0);
		end

		@(negedge clock);
		if (completed != issued) begin
			report_error($sformatf("%0d instructions issued but %0d completed",
				issued, completed));
		end
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

	initial begin
		#(max_instr * max_cycles * clock_period);
		$display("Watchdog expired: the run did not finish within %0d cycles",
			max_instr * max_cycles);
		$display("Testbench failed");
		$finish;
	end

endmodule

// ==== hw/exec_core.sv ====
/*
 * Execute stage top level. Connects the controller, the ALU, the iterative
 * shift/multiply/divide unit and the data bus port.
 */
`timescale 1ns/1ps

module exec_core #(
	parameter bit ENABLE_MUL_DIV = 1'b1
) (
	input logic clock,
	input logic reset,
	input logic decode_valid,
	input logic instr_c,
	input exec_pkg::op_type_e op_type,
	input exec_pkg::op_t op,
	input exec_pkg::word_t op_a,
	input exec_pkg::word_t op_b,
	input exec_pkg::word_t op_c,
	input exec_pkg::reg_addr_t rd,
	output logic instr_complete,
	output exec_pkg::reg_addr_t rd_waddr,
	output exec_pkg::word_t rd_wdata,
	output logic rd_wen,
	output exec_pkg::word_t pc,
	output logic pc_seq,
	output exec_pkg::word_t daddr,
	output logic dvalid,
	output logic dwrite,
	output exec_pkg::word_t dwdata,
	output exec_pkg::byte_en_t dwstb,
	input exec_pkg::word_t drdata,
	input logic dready
);

	exec_pkg::word_t alu_a;
	exec_pkg::word_t alu_b;
	exec_pkg::alu_op_e alu_op;
	exec_pkg::word_t alu_out;

	mds_if mds ();
	mem_if mem ();

	exec_ctrl exec_ctrl_i (.*);

	alu alu_i (
		.a(alu_a),
		.b(alu_b),
		.op(alu_op),
		.result(alu_out)
	);

	mul_div_shift #(
		.ENABLE_MUL_DIV(ENABLE_MUL_DIV)
	) mul_div_shift_i (.*);

	data_mem_port data_mem_port_i (.*);

endmodule

// ==== hw/exec_ctrl.sv ====
/*
 * Execute controller. Runs the per-instruction state machine, steers the
 * ALU, starts shift/multiply/divide and memory jobs, and produces the
 * register write-back, instr_complete and the next PC.
 */
`timescale 1ns/1ps

module exec_ctrl (
	input logic clock,
	input logic reset,
	input logic decode_valid,
	input logic instr_c,
	input exec_pkg::op_type_e op_type,
	input exec_pkg::op_t op,
	input exec_pkg::word_t op_a,
	input exec_pkg::word_t op_b,
	input exec_pkg::word_t op_c,
	input exec_pkg::reg_addr_t rd,
	output logic instr_complete,
	output exec_pkg::reg_addr_t rd_waddr,
	output exec_pkg::word_t rd_wdata,
	output logic rd_wen,
	output exec_pkg::word_t pc,
	output logic pc_seq,
	output exec_pkg::word_t alu_a,
	output exec_pkg::word_t alu_b,
	output exec_pkg::alu_op_e alu_op,
	input exec_pkg::word_t alu_out,
	mds_if.ctrl mds,
	mem_if.ctrl mem
);

	exec_pkg::exec_state_e state;
	logic go;
	logic is_load;
	logic [2:0] pc_incr;
	exec_pkg::word_t seq_pc;

	// Decode stays valid during the complete cycle, so it must not restart
	assign go = (state == exec_pkg::st_execute) && decode_valid && !instr_complete;
	assign is_load = exec_pkg::mem_op_e'(op) inside {exec_pkg::mem_lb, exec_pkg::mem_lh,
		exec_pkg::mem_lw, exec_pkg::mem_lbu, exec_pkg::mem_lhu};

	// Zero increment in branch_taken so operand A is the branch's own pc
	assign pc_incr = (state == exec_pkg::st_branch_taken) ? 3'd0 : (instr_c ? 3'd2 : 3'd4);
	assign seq_pc = pc + {29'd0, pc_incr};

	always_comb begin
		alu_a = op_a;
		alu_b = op_b;
		alu_op = exec_pkg::alu_op_e'(op);
		case (state)
			exec_pkg::st_execute: begin
				if (op_type == exec_pkg::op_type_ldst) begin
					// Address is base plus offset
					alu_b = op_c;
					alu_op = exec_pkg::alu_add;
				end else if (op_type == exec_pkg::op_type_jump) begin
					// Link value
					alu_a = seq_pc;
					alu_b = '0;
					alu_op = exec_pkg::alu_add;
				end
			end
			exec_pkg::st_branch_taken: begin
				alu_a = seq_pc;
				alu_b = op_c;
				alu_op = exec_pkg::alu_add;
			end
			exec_pkg::st_jump: begin
				alu_b = op_c;
				alu_op = exec_pkg::alu_add;
			end
			default: begin
			end
		endcase
	end

	always_comb begin
		rd_waddr = rd;
		rd_wdata = alu_out;
		rd_wen = 1'b0;
		case (state)
			exec_pkg::st_execute: begin
				rd_wen = go && (op_type == exec_pkg::op_type_arith
					|| op_type == exec_pkg::op_type_jump);
			end
			exec_pkg::st_mds_wait: begin
				rd_wdata = mds.result;
				rd_wen = mds.out_valid;
			end
			exec_pkg::st_ldst_wait: begin
				rd_wdata = mem.ack_data;
				rd_wen = mem.ack_valid && is_load;
			end
			default: begin
			end
		endcase
	end

	assign mds.in_valid = go && (op_type == exec_pkg::op_type_mds);
	assign mds.in_a = op_a;
	assign mds.in_b = op_b;
	assign mds.op = op;

	// Store data comes from op_b
	assign mem.req_valid = go && (op_type == exec_pkg::op_type_ldst);
	assign mem.req_addr = alu_out;
	assign mem.req_op = op;
	assign mem.req_data = op_b;

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= exec_pkg::st_execute;
			instr_complete <= 1'b0;
			pc <= exec_pkg::reset_pc;
			pc_seq <= 1'b1;
		end else begin
			instr_complete <= 1'b0;
			case (state)
				exec_pkg::st_execute: begin
					if (go) begin
						case (op_type)
							exec_pkg::op_type_ldst: state <= exec_pkg::st_ldst_wait;
							exec_pkg::op_type_mds: state <= exec_pkg::st_mds_wait;
							exec_pkg::op_type_jump: state <= exec_pkg::st_jump;
							default: begin
								if (op_type == exec_pkg::op_type_branch && alu_out[0]) begin
									state <= exec_pkg::st_branch_taken;
								end else begin
									pc <= seq_pc;
									pc_seq <= 1'b1;
									instr_complete <= 1'b1;
								end
							end
						endcase
					end
				end
				exec_pkg::st_branch_taken, exec_pkg::st_jump: begin
					pc <= alu_out;
					pc_seq <= 1'b0;
					instr_complete <= 1'b1;
					state <= exec_pkg::st_execute;
				end
				default: begin
					// Wait states finish on the unit's pulse
					if ((state == exec_pkg::st_mds_wait && mds.out_valid)
							|| (state == exec_pkg::st_ldst_wait && mem.ack_valid)) begin
						pc <= seq_pc;
						pc_seq <= 1'b1;
						instr_complete <= 1'b1;
						state <= exec_pkg::st_execute;
					end
				end
			endcase
		end
	end

endmodule

// ==== hw/data_mem_port.sv ====
/*
 * Data bus port for one load or store at a time. Latches the request,
 * holds dvalid until dready, and returns the extended load value with ack.
 */
`timescale 1ns/1ps

module data_mem_port (
	input logic clock,
	input logic reset,
	mem_if.port mem,
	output exec_pkg::word_t daddr,
	output logic dvalid,
	output logic dwrite,
	output exec_pkg::word_t dwdata,
	output exec_pkg::byte_en_t dwstb,
	input exec_pkg::word_t drdata,
	input logic dready
);

	exec_pkg::mem_op_e req_op;
	exec_pkg::mem_op_e op_r;
	logic is_store;
	exec_pkg::word_t lane_data;

	assign req_op = exec_pkg::mem_op_e'(mem.req_op);
	assign is_store = req_op inside {exec_pkg::mem_sb, exec_pkg::mem_sh, exec_pkg::mem_sw};

	always_ff @(posedge clock) begin
		if (reset) begin
			dvalid <= 1'b0;
			dwrite <= 1'b0;
		end else if (mem.req_valid) begin
			dvalid <= 1'b1;
			dwrite <= is_store;
		end else if (dvalid && dready) begin
			dvalid <= 1'b0;
			dwrite <= 1'b0;
		end
	end

	// Store data goes out on every lane and the strobe picks the bytes
	always_ff @(posedge clock) begin
		if (mem.req_valid) begin
			daddr <= mem.req_addr;
			op_r <= req_op;
			case (req_op)
				exec_pkg::mem_sb: begin
					dwdata <= {4{mem.req_data[7:0]}};
					dwstb <= 4'b0001 << mem.req_addr[1:0];
				end
				exec_pkg::mem_sh: begin
					dwdata <= {2{mem.req_data[15:0]}};
					dwstb <= mem.req_addr[1] ? 4'b1100 : 4'b0011;
				end
				exec_pkg::mem_sw: begin
					dwdata <= mem.req_data;
					dwstb <= 4'b1111;
				end
				default: begin
					dwdata <= mem.req_data;
					dwstb <= 4'b0000;
				end
			endcase
		end
	end

	assign mem.ack_valid = dvalid && dready;
	assign lane_data = drdata >> {daddr[1:0], 3'b000};

	always_comb begin
		case (op_r)
			exec_pkg::mem_lb: mem.ack_data = {{24{lane_data[7]}}, lane_data[7:0]};
			exec_pkg::mem_lbu: mem.ack_data = {24'd0, lane_data[7:0]};
			exec_pkg::mem_lh: mem.ack_data = {{16{lane_data[15]}}, lane_data[15:0]};
			exec_pkg::mem_lhu: mem.ack_data = {16'd0, lane_data[15:0]};
			default: mem.ack_data = lane_data;
		endcase
	end

endmodule

// ==== hw/mul_div_shift.sv ====
/*
 * Iterative shift, multiply and divide unit. A job starts on the in_valid
 * pulse and ends with an out_valid pulse: shifts take one cycle per bit,
 * multiply and divide 32 steps. With ENABLE_MUL_DIV at 0 multiply and
 * divide give zero after one cycle.
 */
`timescale 1ns/1ps

module mul_div_shift #(
	parameter bit ENABLE_MUL_DIV = 1'b1
) (
	input logic clock,
	input logic reset,
	mds_if.unit mds
);

	logic busy;
	logic [5:0] count;
	exec_pkg::mds_op_e op_r;
	// Product hi:lo, or remainder:quotient while dividing
	logic [63:0] acc;
	exec_pkg::word_t operand;
	logic neg_res;
	logic neg_rem;

	exec_pkg::mds_op_e op_in;
	logic is_shift_in;
	logic is_shift_r;
	logic a_neg;
	logic b_neg;
	exec_pkg::word_t a_mag;
	exec_pkg::word_t b_mag;
	logic [32:0] mul_sum;
	logic [33:0] div_diff;
	logic [63:0] product;

	always_comb begin
		op_in = exec_pkg::mds_op_e'(mds.op);
		is_shift_in = op_in inside {exec_pkg::mds_sll, exec_pkg::mds_srl, exec_pkg::mds_sra};
		// Signed ops work on magnitudes and fix the sign at the end
		a_neg = mds.in_a[31] && (op_in inside {exec_pkg::mds_mul, exec_pkg::mds_mulh,
			exec_pkg::mds_div, exec_pkg::mds_rem});
		b_neg = mds.in_b[31] && (op_in inside {exec_pkg::mds_mul, exec_pkg::mds_mulh,
			exec_pkg::mds_div, exec_pkg::mds_rem});
		a_mag = a_neg ? -mds.in_a : mds.in_a;
		b_mag = b_neg ? -mds.in_b : mds.in_b;
	end

	assign is_shift_r = op_r inside {exec_pkg::mds_sll, exec_pkg::mds_srl, exec_pkg::mds_sra};
	assign mul_sum = {1'b0, acc[63:32]} + (acc[0] ? {1'b0, operand} : 33'd0);
	// Restoring step on the remainder shifted left by one
	assign div_diff = {1'b0, acc[63:31]} - {2'b00, operand};
	assign product = neg_res ? -acc : acc;

	always_ff @(posedge clock) begin
		if (reset) begin
			busy <= 1'b0;
			count <= 6'd0;
		end else if (mds.in_valid) begin
			busy <= 1'b1;
			if (is_shift_in) begin
				count <= {1'b0, mds.in_b[4:0]};
			end else begin
				count <= ENABLE_MUL_DIV ? 6'd32 : 6'd0;
			end
		end else if (busy) begin
			if (count == 6'd0) begin
				busy <= 1'b0;
			end else begin
				count <= count - 6'd1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (mds.in_valid) begin
			op_r <= op_in;
			neg_rem <= a_neg;
			case (op_in)
				exec_pkg::mds_mul, exec_pkg::mds_mulh: begin
					acc <= {32'd0, b_mag};
					operand <= a_mag;
					neg_res <= a_neg ^ b_neg;
				end
				exec_pkg::mds_div, exec_pkg::mds_divu,
				exec_pkg::mds_rem, exec_pkg::mds_remu: begin
					acc <= {32'd0, a_mag};
					operand <= b_mag;
					// Divide by zero leaves the quotient all ones
					neg_res <= (a_neg ^ b_neg) && (mds.in_b != '0);
				end
				default: begin
					acc <= {32'd0, mds.in_a};
					operand <= mds.in_b;
					neg_res <= 1'b0;
				end
			endcase
		end else if (busy && count != 6'd0) begin
			case (op_r)
				exec_pkg::mds_sll: acc[31:0] <= {acc[30:0], 1'b0};
				exec_pkg::mds_srl: acc[31:0] <= {1'b0, acc[31:1]};
				exec_pkg::mds_sra: acc[31:0] <= {acc[31], acc[31:1]};
				exec_pkg::mds_mul, exec_pkg::mds_mulh: acc <= {mul_sum, acc[31:1]};
				default: begin
					if (div_diff[33]) begin
						acc <= {acc[62:0], 1'b0};
					end else begin
						acc <= {div_diff[31:0], acc[30:0], 1'b1};
					end
				end
			endcase
		end
	end

	always_comb begin
		case (op_r)
			exec_pkg::mds_mul: mds.result = product[31:0];
			exec_pkg::mds_mulh: mds.result = product[63:32];
			exec_pkg::mds_div, exec_pkg::mds_divu: mds.result = neg_res ? -acc[31:0] : acc[31:0];
			exec_pkg::mds_rem, exec_pkg::mds_remu: mds.result = neg_rem ? -acc[63:32] : acc[63:32];
			default: mds.result = acc[31:0];
		endcase
		if (!ENABLE_MUL_DIV && !is_shift_r) begin
			mds.result = '0;
		end
	end

	assign mds.out_valid = busy && (count == 6'd0);

endmodule

// ==== hw/alu.sv ====
/*
 * Combinational ALU for arithmetic, branch compares and address sums.
 * Compare results are 0 or 1 in bit 0.
 */
`timescale 1ns/1ps

module alu (
	input exec_pkg::word_t a,
	input exec_pkg::word_t b,
	input exec_pkg::alu_op_e op,
	output exec_pkg::word_t result
);

	logic lt_s;
	logic lt_u;

	assign lt_s = $signed(a) < $signed(b);
	assign lt_u = a < b;

	always_comb begin
		case (op)
			exec_pkg::alu_add: result = a + b;
			exec_pkg::alu_sub: result = a - b;
			exec_pkg::alu_and: result = a & b;
			exec_pkg::alu_or: result = a | b;
			exec_pkg::alu_xor: result = a ^ b;
			exec_pkg::alu_slt, exec_pkg::alu_lt: result = {31'd0, lt_s};
			exec_pkg::alu_sltu, exec_pkg::alu_ltu: result = {31'd0, lt_u};
			exec_pkg::alu_eq: result = {31'd0, a == b};
			exec_pkg::alu_ne: result = {31'd0, a != b};
			exec_pkg::alu_ge: result = {31'd0, !lt_s};
			exec_pkg::alu_geu: result = {31'd0, !lt_u};
			exec_pkg::alu_pass_b: result = b;
			default: result = '0;
		endcase
	end

endmodule

// ==== hw/exec_intf.sv ====
/*
 * Internal links of the execute stage. mds_if carries one shift, multiply
 * or divide job to the iterative unit, mem_if one load or store to the bus port.
 */
`timescale 1ns/1ps

interface mds_if;
	exec_pkg::word_t in_a;
	exec_pkg::word_t in_b;
	exec_pkg::op_t op;
	logic in_valid;
	exec_pkg::word_t result;
	logic out_valid;

	modport ctrl (output in_a, in_b, op, in_valid, input result, out_valid);
	modport unit (input in_a, in_b, op, in_valid, output result, out_valid);
endinterface

interface mem_if;
	logic req_valid;
	exec_pkg::word_t req_addr;
	exec_pkg::op_t req_op;
	exec_pkg::word_t req_data;
	// Load value already shifted and extended
	logic ack_valid;
	exec_pkg::word_t ack_data;

	modport ctrl (output req_valid, req_addr, req_op, req_data, input ack_valid, ack_data);
	modport port (input req_valid, req_addr, req_op, req_data, output ack_valid, ack_data);
endinterface

// ==== hw/exec_pkg.sv ====
/*
 * Shared widths, operation encodings and constants for the execute stage.
 * Design files refer to these by exec_pkg:: scoped names.
 */
package exec_pkg;

	localparam int word_w = 32;
	localparam int reg_addr_w = 5;

	typedef logic [word_w-1:0] word_t;
	typedef logic [reg_addr_w-1:0] reg_addr_t;
	typedef logic [word_w/8-1:0] byte_en_t;
	typedef logic [3:0] op_t;

	// Instruction class from decode
	typedef enum logic [2:0] {
		op_type_arith = 3'd0,
		op_type_branch = 3'd1,
		op_type_ldst = 3'd2,
		op_type_mds = 3'd3,
		op_type_jump = 3'd4
	} op_type_e;

	// ALU operations with compares returning 0 or 1
	typedef enum logic [3:0] {
		alu_add = 4'd0,
		alu_sub = 4'd1,
		alu_and = 4'd2,
		alu_or = 4'd3,
		alu_xor = 4'd4,
		alu_slt = 4'd5,
		alu_sltu = 4'd6,
		alu_eq = 4'd7,
		alu_ne = 4'd8,
		alu_lt = 4'd9,
		alu_ge = 4'd10,
		alu_ltu = 4'd11,
		alu_geu = 4'd12,
		alu_pass_b = 4'd13
	} alu_op_e;

	typedef enum logic [3:0] {
		mds_sll = 4'd0,
		mds_srl = 4'd1,
		mds_sra = 4'd2,
		mds_mul = 4'd3,
		mds_mulh = 4'd4,
		mds_div = 4'd5,
		mds_divu = 4'd6,
		mds_rem = 4'd7,
		mds_remu = 4'd8
	} mds_op_e;

	typedef enum logic [3:0] {
		mem_lb = 4'd0,
		mem_lh = 4'd1,
		mem_lw = 4'd2,
		mem_lbu = 4'd3,
		mem_lhu = 4'd4,
		mem_sb = 4'd5,
		mem_sh = 4'd6,
		mem_sw = 4'd7
	} mem_op_e;

	typedef enum logic [2:0] {
		st_execute = 3'd0,
		st_branch_taken = 3'd1,
		st_jump = 3'd2,
		st_mds_wait = 3'd3,
		st_ldst_wait = 3'd4
	} exec_state_e;

	localparam word_t reset_pc = 32'h8000_0000;

endpackage
